// File: src/cdot_settings.svh
`ifndef CDOT_SETTINGS_SVH
`define CDOT_SETTINGS_SVH

// complex pairs per transfer
// must stay a power of two
`define CDOT_VEC_LEN 8

// tree depth, log2 of the vector length
`define CDOT_LEN_LOG 3

// signed width of one real or imaginary part
`define CDOT_DATA_W 16

// right shift applied to the final sum
`define CDOT_SHIFT_W 4

`endif

// File: src/cdot_cfg_pkg.sv
`include "cdot_settings.svh"

package cdot_cfg_pkg;

  // engine configuration word
  typedef struct packed {
    logic                     conj_en;
    logic [`CDOT_SHIFT_W-1:0] shift;
  } cdot_cfg_t;

  // request payload of the config port
  // we low means a plain read
  typedef struct packed {
    logic      we;
    cdot_cfg_t wdata;
  } cfg_req_t;

endpackage

// File: src/cdot_data_pkg.sv
`include "cdot_settings.svh"

package cdot_data_pkg;

  // product needs one guard bit above the two partial products
  localparam int unsigned PROD_W = 2 * `CDOT_DATA_W + 1;
  // one growth bit per tree level
  localparam int unsigned RES_W = PROD_W + `CDOT_LEN_LOG;

  typedef struct packed {
    logic signed [`CDOT_DATA_W-1:0] re;
    logic signed [`CDOT_DATA_W-1:0] im;
  } cplx_op_t;

  typedef struct packed {
    cplx_op_t a;
    cplx_op_t b;
  } cplx_pair_t;

  typedef struct packed {
    logic signed [PROD_W-1:0] re;
    logic signed [PROD_W-1:0] im;
  } cplx_prod_t;

  // tree nodes and the final result
  typedef struct packed {
    logic signed [RES_W-1:0] re;
    logic signed [RES_W-1:0] im;
  } cplx_res_t;

endpackage

// File: src/cdot_cfg_regs.sv
`timescale 1ns/1ps

module cdot_cfg_regs (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // four-phase request side
  input  logic                    cfg_req_i,
  input  cdot_cfg_pkg::cfg_req_t  cfg_i,
  output logic                    cfg_ack_o,
  output cdot_cfg_pkg::cdot_cfg_t cfg_rdata_o,
  // live configuration to the datapath
  output cdot_cfg_pkg::cdot_cfg_t cfg_o
);

  import cdot_cfg_pkg::*;

  cdot_cfg_t cfg_q;
  logic      ack_q;
  logic      ack_rise;

  // request seen high but not yet acknowledged
  assign ack_rise = cfg_req_i & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      cfg_q <= '0;
    end else begin
      // ack trails the request by one clock in both directions
      ack_q <= cfg_req_i;
      // write once per handshake on the rising ack edge
      if (ack_rise && cfg_i.we) begin
        cfg_q <= cfg_i.wdata;
      end
    end
  end

  assign cfg_ack_o = ack_q;

  // read data is the register itself
  // valid by the time ack is seen high
  assign cfg_rdata_o = cfg_q;
  assign cfg_o       = cfg_q;

endmodule

// File: src/complex_mul.sv
`timescale 1ns/1ps
`include "cdot_settings.svh"

module complex_mul (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         adv_i,
  input  cdot_data_pkg::cplx_pair_t [`CDOT_VEC_LEN-1:0] pairs_i,
  input  logic                                         conj_i,
  output cdot_data_pkg::cplx_prod_t [`CDOT_VEC_LEN-1:0] prod_o
);

  import cdot_data_pkg::*;

  localparam int unsigned VEC_LEN = `CDOT_VEC_LEN;
  localparam int unsigned DATA_W  = `CDOT_DATA_W;

  cplx_prod_t [VEC_LEN-1:0] prod_d;
  cplx_prod_t [VEC_LEN-1:0] prod_q;

  // all lanes in parallel
  always_comb begin
    logic signed [DATA_W-1:0] ar;
    logic signed [DATA_W-1:0] ai;
    logic signed [DATA_W-1:0] br;
    logic signed [DATA_W-1:0] bi;
    logic signed [DATA_W:0]   bi_ext;
    logic signed [DATA_W:0]   bi_eff;
    for (int k = 0; k < VEC_LEN; k++) begin
      ar = pairs_i[k].a.re;
      ai = pairs_i[k].a.im;
      br = pairs_i[k].b.re;
      bi = pairs_i[k].b.im;
      // one extra bit so negating the most negative value stays exact
      bi_ext = (DATA_W + 1)'(bi);
      // conjugate of b flips its imaginary part
      bi_eff = conj_i ? -bi_ext : bi_ext;
      // signed operands are widened to PROD_W before the multiply
      prod_d[k].re = ar * br - ai * bi_eff;
      prod_d[k].im = ai * br + ar * bi_eff;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prod_q <= '0;
    end else if (adv_i) begin
      // whole stage moves with the global enable
      prod_q <= prod_d;
    end
  end

  assign prod_o = prod_q;

endmodule

// File: src/complex_add_tree.sv
`timescale 1ns/1ps
`include "cdot_settings.svh"

module complex_add_tree (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         adv_i,
  input  logic                                         flush_i,
  input  logic                                         valid_i,
  input  logic [`CDOT_SHIFT_W-1:0]                     shift_i,
  input  cdot_data_pkg::cplx_prod_t [`CDOT_VEC_LEN-1:0] prod_i,
  output logic                                         valid_o,
  output logic [`CDOT_LEN_LOG-1:0]                     lvl_valid_o,
  output cdot_data_pkg::cplx_res_t                     sum_o
);

  import cdot_data_pkg::*;

  localparam int unsigned VEC_LEN = `CDOT_VEC_LEN;
  localparam int unsigned LEN_LOG = `CDOT_LEN_LOG;
  localparam int unsigned SHIFT_W = `CDOT_SHIFT_W;

  // all tree nodes, level after level
  // level l starts at VEC_LEN - (VEC_LEN >> l), the root is last
  cplx_res_t node_q [VEC_LEN-1];

  logic [LEN_LOG-1:0]              vld_q;
  logic [LEN_LOG-1:0][SHIFT_W-1:0] shift_q;

  for (genvar l = 0; l < LEN_LOG; l++) begin : g_lvl
    localparam int NOUT = VEC_LEN >> (l + 1);
    localparam int BASE = VEC_LEN - (VEC_LEN >> l);
    // start of the level below, only meaningful above level 0
    localparam int PREV = VEC_LEN - ((2 * VEC_LEN) >> l);

    for (genvar j = 0; j < NOUT; j++) begin : g_node
      cplx_res_t op_a;
      cplx_res_t op_b;

      if (l == 0) begin : g_leaf
        // sign extend the products to full result width
        always_comb begin
          op_a.re = RES_W'($signed(prod_i[2*j].re));
          op_a.im = RES_W'($signed(prod_i[2*j].im));
          op_b.re = RES_W'($signed(prod_i[2*j+1].re));
          op_b.im = RES_W'($signed(prod_i[2*j+1].im));
        end
      end else begin : g_inner
        assign op_a = node_q[PREV + 2*j];
        assign op_b = node_q[PREV + 2*j + 1];
      end

      always_ff @(posedge clk_i) begin
        if (adv_i) begin
          node_q[BASE + j].re <= op_a.re + op_b.re;
          node_q[BASE + j].im <= op_a.im + op_b.im;
        end
      end
    end
  end

  // valid bit per level, dropped by flush
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0;
    end else if (adv_i) begin
      vld_q[0] <= valid_i;
      for (int l = 1; l < LEN_LOG; l++) begin
        vld_q[l] <= vld_q[l-1];
      end
    end
  end

  // shift amount rides along with its item
  always_ff @(posedge clk_i) begin
    if (adv_i) begin
      shift_q[0] <= shift_i;
      for (int l = 1; l < LEN_LOG; l++) begin
        shift_q[l] <= shift_q[l-1];
      end
    end
  end

  // arithmetic shift on the root
  always_comb begin
    sum_o.re = $signed(node_q[VEC_LEN-2].re) >>> shift_q[LEN_LOG-1];
    sum_o.im = $signed(node_q[VEC_LEN-2].im) >>> shift_q[LEN_LOG-1];
  end

  assign valid_o     = vld_q[LEN_LOG-1];
  assign lvl_valid_o = vld_q;

endmodule

// File: src/complex_dot_product.sv
`timescale 1ns/1ps
`include "cdot_settings.svh"

module complex_dot_product (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // operand side
  input  cdot_data_pkg::cplx_pair_t [`CDOT_VEC_LEN-1:0] operands_i,
  input  cdot_cfg_pkg::cdot_cfg_t                      cfg_i,
  input  logic                                         in_valid_i,
  output logic                                         in_ready_o,
  input  logic                                         flush_i,
  // result side
  output cdot_data_pkg::cplx_res_t                     result_o,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  // any item in flight
  output logic                                         busy_o
);

  import cdot_data_pkg::*;

  localparam int unsigned VEC_LEN = `CDOT_VEC_LEN;
  localparam int unsigned LEN_LOG = `CDOT_LEN_LOG;
  localparam int unsigned SHIFT_W = `CDOT_SHIFT_W;

  logic                     adv;
  logic                     mul_vld_q;
  logic [SHIFT_W-1:0]       mul_shift_q;
  cplx_prod_t [VEC_LEN-1:0] prod;
  logic [LEN_LOG-1:0]       lvl_valid;

  // single stall for the whole pipe
  // moves unless the output holds an untaken result
  assign adv        = ~out_valid_o | out_ready_i;
  assign in_ready_o = adv;

  // valid of the multiplier stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mul_vld_q <= 1'b0;
    end else if (flush_i) begin
      mul_vld_q <= 1'b0;
    end else if (adv) begin
      mul_vld_q <= in_valid_i;
    end
  end

  // shift sampled at acceptance like conj_en
  always_ff @(posedge clk_i) begin
    if (adv) begin
      mul_shift_q <= cfg_i.shift;
    end
  end

  complex_mul u_mul (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .adv_i    (adv),
    .pairs_i  (operands_i),
    .conj_i   (cfg_i.conj_en),
    .prod_o   (prod)
  );

  complex_add_tree u_tree (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .adv_i       (adv),
    .flush_i     (flush_i),
    .valid_i     (mul_vld_q),
    .shift_i     (mul_shift_q),
    .prod_i      (prod),
    .valid_o     (out_valid_o),
    .lvl_valid_o (lvl_valid),
    .sum_o       (result_o)
  );

  // output valid is the last level valid, so it is covered here
  assign busy_o = mul_vld_q | (|lvl_valid);

endmodule

// File: src/cdot_top.sv
`timescale 1ns/1ps
`include "cdot_settings.svh"

module cdot_top (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // config port
  input  logic                                         cfg_req_i,
  input  cdot_cfg_pkg::cfg_req_t                       cfg_i,
  output logic                                         cfg_ack_o,
  output cdot_cfg_pkg::cdot_cfg_t                      cfg_rdata_o,
  // data port
  input  cdot_data_pkg::cplx_pair_t [`CDOT_VEC_LEN-1:0] operands_i,
  input  logic                                         in_valid_i,
  output logic                                         in_ready_o,
  input  logic                                         flush_i,
  output cdot_data_pkg::cplx_res_t                     result_o,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  output logic                                         busy_o
);

  import cdot_cfg_pkg::*;

  // live config into the datapath
  cdot_cfg_t cfg;

  cdot_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_i       (cfg_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .cfg_o       (cfg)
  );

  complex_dot_product u_datapath (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .operands_i  (operands_i),
    .cfg_i       (cfg),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

endmodule

// File: testbench/cdot_assertions.sv
`timescale 1ns/1ps

module cdot_assertions (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     flush_i,
  input logic                     out_valid_o,
  input logic                     out_ready_i,
  input cdot_data_pkg::cplx_res_t result_o,
  input logic                     busy_o
);

  // failed assertion count
  int fail_cnt = 0;

  // stalled result holds until taken unless flushed
  hold_while_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o))
    else begin
      fail_cnt++;
      $error("result or valid moved while stalled");
    end

  // async reset clears the output side
  low_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> !out_valid_o && !busy_o)
    else begin
      fail_cnt++;
      $error("outputs not low during reset");
    end

  // flush empties every stage by the next edge
  flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      flush_i |=> !busy_o && !out_valid_o)
    else begin
      fail_cnt++;
      $error("items still in flight after flush");
    end

endmodule

// File: testbench/tb_cdot.sv
`timescale 1ns/1ps
`include "cdot_settings.svh"

module tb_cdot;

  import cdot_data_pkg::*;
  import cdot_cfg_pkg::*;

  localparam int VEC_LEN = `CDOT_VEC_LEN;
  localparam int LATENCY = 1 + `CDOT_LEN_LOG;
  // 5 tests, at most 32 items each, latency plus worst stall, then margin
  localparam int TIMEOUT_CYCLES = 5 * 32 * (LATENCY + 16) + 1000;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      cfg_req_i;
  cfg_req_t                  cfg_i;
  logic                      cfg_ack_o;
  cdot_cfg_t                 cfg_rdata_o;
  cplx_pair_t [VEC_LEN-1:0]  operands_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic                      flush_i;
  cplx_res_t                 result_o;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic                      busy_o;

  // scoreboard state
  cplx_res_t   exp_q[$];
  int          acc_q[$];
  cdot_cfg_t   tb_cfg;
  logic [15:0] lfsr_q;
  logic        check_lat;
  int          cycle;
  int          errors;
  int          checks;
  int          n_tests;
  int          err_mark;
  int          n_acc;
  int          n_out;

  cdot_top u_dut (.*);

  bind complex_dot_product cdot_assertions u_checks (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // galois step, taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic random_vector(output cplx_pair_t [VEC_LEN-1:0] v);
    logic [31:0] r;
    for (int k = 0; k < VEC_LEN; k++) begin
      take_bits(32, r);
      v[k].a = r;
      take_bits(32, r);
      v[k].b = r;
    end
  endtask

  // sum of a*b or a*conj(b), then arithmetic shift
  function automatic cplx_res_t ref_dot(input cplx_pair_t [VEC_LEN-1:0] ops,
                                        input cdot_cfg_t cfg);
    longint    sum_re;
    longint    sum_im;
    longint    bi;
    cplx_res_t res;
    sum_re = 0;
    sum_im = 0;
    for (int k = 0; k < VEC_LEN; k++) begin
      bi = ops[k].b.im;
      // conj flips the imaginary part of b
      if (cfg.conj_en) bi = -bi;
      sum_re += longint'(ops[k].a.re) * ops[k].b.re - longint'(ops[k].a.im) * bi;
      sum_im += longint'(ops[k].a.im) * ops[k].b.re + longint'(ops[k].a.re) * bi;
    end
    res.re = sum_re >>> cfg.shift;
    res.im = sum_im >>> cfg.shift;
    return res;
  endfunction

  task automatic check_eq(input logic [127:0] got, input logic [127:0] want,
                          input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("%-20s %s, %0d errors", name, (errors == err_mark) ? "ok" : "bad",
             errors - err_mark);
    err_mark = errors;
  endtask

  task automatic stop_input();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // present one vector, return on the accepting edge
  task automatic send_vector();
    cplx_pair_t [VEC_LEN-1:0] v;
    @(negedge clk_i);
    random_vector(v);
    operands_i = v;
    in_valid_i = 1'b1;
    do @(posedge clk_i); while (!in_ready_o);
  endtask

  task automatic drain();
    stop_input();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // four-phase access, ack expected one cycle after each request edge
  task automatic cfg_access(input logic we, input cdot_cfg_t word, output cdot_cfg_t rd);
    int n;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    check_eq(cfg_ack_o, 0, "ack low before request");
    cfg_i.we    = we;
    cfg_i.wdata = word;
    cfg_req_i   = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cfg_ack_o);
    check_eq(n, 1, "cycles to ack rise");
    rd = cfg_rdata_o;
    if (we) tb_cfg = word;
    cfg_req_i = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (cfg_ack_o);
    check_eq(n, 1, "cycles to ack fall");
  endtask

  // compare on output handshakes, record expectations at acceptance
  always @(posedge clk_i) begin : monitor
    cplx_res_t exp_res;
    int        t0;
    if (arst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        n_out++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected result at %0t ns with nothing outstanding", $time);
        end else begin
          exp_res = exp_q.pop_front();
          t0      = acc_q.pop_front();
          check_eq(result_o, exp_res, "dot product result");
          if (check_lat) check_eq(cycle - t0, LATENCY, "accept to output latency");
        end
      end
      // flush drops everything in flight, an item accepted now included
      if (flush_i) begin
        exp_q.delete();
        acc_q.delete();
      end else if (in_valid_i && in_ready_o) begin
        exp_q.push_back(ref_dot(operands_i, tb_cfg));
        acc_q.push_back(cycle);
        n_acc++;
      end
    end
    cycle++;
  end

  initial begin : watchdog
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    cdot_cfg_t                word;
    cdot_cfg_t                rd;
    logic [31:0]              r;
    cplx_pair_t [VEC_LEN-1:0] v;
    logic                     pending;
    int                       sent;
    int                       mark_acc;
    int                       mark_out;
    int                       afails;
    arst_n_i    = 1'b1;
    cfg_req_i   = 1'b0;
    cfg_i       = '0;
    operands_i  = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    flush_i     = 1'b0;
    tb_cfg      = '0;
    lfsr_q      = 16'd40;
    check_lat   = 1'b0;
    #1 arst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // plain products, no shift, fixed latency
    mark_out  = n_out;
    check_lat = 1'b1;
    repeat (20) send_vector();
    drain();
    check_lat = 1'b0;
    check_eq(n_out - mark_out, 20, "results out of basic stream");
    end_test("basic dot product");

    // write then read back with junk in wdata
    take_bits(5, r);
    word = r[4:0];
    cfg_access(1'b1, word, rd);
    take_bits(5, r);
    cfg_access(1'b0, r[4:0], rd);
    check_eq(rd, word, "config read back");
    end_test("config port");

    // new shift before each vector while older ones are still in flight
    for (int i = 0; i < 12; i++) begin
      take_bits(4, r);
      cfg_access(1'b1, {1'b1, r[3:0]}, rd);
      send_vector();
    end
    drain();
    end_test("conjugate and shift");

    // random ready while the input streams
    mark_acc = n_acc;
    mark_out = n_out;
    sent     = 0;
    pending  = 1'b0;
    while (sent < 30) begin
      @(negedge clk_i);
      take_bits(1, r);
      out_ready_i = r[0];
      if (!pending) begin
        random_vector(v);
        operands_i = v;
        in_valid_i = 1'b1;
        pending    = 1'b1;
      end
      @(posedge clk_i);
      if (in_ready_o) begin
        pending = 1'b0;
        sent++;
      end
    end
    do begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
      take_bits(1, r);
      out_ready_i = r[0];
    end while (exp_q.size() != 0);
    out_ready_i = 1'b1;
    check_eq(n_out - mark_out, n_acc - mark_acc, "items out versus accepted");
    end_test("back-pressure");

    // fill the stalled pipe, then drop it
    out_ready_i = 1'b0;
    repeat (3) send_vector();
    stop_input();
    repeat (2) @(negedge clk_i);
    check_eq(busy_o, 1, "busy with items held");
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_eq(busy_o, 0, "busy after flush");
    check_eq(out_valid_o, 0, "out valid after flush");
    out_ready_i = 1'b1;
    send_vector();
    drain();
    repeat (LATENCY) @(negedge clk_i);
    end_test("flush");

    afails = u_dut.u_datapath.u_checks.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, checks, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+src
src/cdot_cfg_pkg.sv
src/cdot_data_pkg.sv
src/cdot_cfg_regs.sv
src/complex_mul.sv
src/complex_add_tree.sv
src/complex_dot_product.sv
src/cdot_top.sv
testbench/cdot_assertions.sv
testbench/tb_cdot.sv

// File: Bender.yml
package:
  name: cdot

sources:
  - include_dirs:
      - src
    files:
      - src/cdot_cfg_pkg.sv
      - src/cdot_data_pkg.sv
      - src/cdot_cfg_regs.sv
      - src/complex_mul.sv
      - src/complex_add_tree.sv
      - src/complex_dot_product.sv
      - src/cdot_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/cdot_assertions.sv
      - testbench/tb_cdot.sv
